//--- common/apb_pkg.sv
package apb_pkg;

    // bus widths shared by the completer and requester ports
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    // bytes per data word, used for address stepping
    localparam int unsigned WORD_BYTES = DATA_W / 8;

    // one bus address
    typedef logic [ADDR_W-1:0] addr_t;

    // one bus data word
    typedef logic [DATA_W-1:0] data_t;

endpackage

//--- common/dma_pkg.sv
package dma_pkg;

    // word count width, max 64k words per transfer
    localparam int unsigned QTY_W = 16;

    typedef logic [QTY_W-1:0] qty_t;

    // offsets decoded on the low address byte
    localparam int unsigned OFS_W = 8;

    // register map
    localparam logic [OFS_W-1:0] REG_SRC    = 8'h00;
    localparam logic [OFS_W-1:0] REG_DST    = 8'h04;
    localparam logic [OFS_W-1:0] REG_QTY    = 8'h08;
    localparam logic [OFS_W-1:0] REG_CTRL   = 8'h0C;
    localparam logic [OFS_W-1:0] REG_STATUS = 8'h10;

    // control bits
    localparam int unsigned CTRL_START = 0;

    // status bits
    localparam int unsigned STAT_BUSY = 0;
    localparam int unsigned STAT_DONE = 1;
    localparam int unsigned STAT_ERR  = 2;

endpackage

//--- dma/dma_regs.sv
module dma_regs (
    input  logic           clk,
    input  logic           rst,
    input  logic           cfg_psel_i,
    input  logic           cfg_penable_i,
    input  logic           cfg_pwrite_i,
    input  apb_pkg::addr_t cfg_paddr_i,
    input  apb_pkg::data_t cfg_pwdata_i,
    output apb_pkg::data_t cfg_prdata_o,
    output logic           cfg_pready_o,
    output logic           cfg_pslverr_o,
    input  logic           fin_i,
    input  logic           err_i,
    output logic           start_o,
    output apb_pkg::addr_t src_o,
    output apb_pkg::addr_t dst_o,
    output dma_pkg::qty_t  qty_o,
    output logic           irq_o
);

    logic [dma_pkg::OFS_W-1:0] ofs;
    logic                      access;
    logic                      wr;
    logic                      mapped;
    logic                      start_acc;
    logic                      clr_done;
    logic                      start_q;
    logic                      busy_q;
    logic                      done_q;
    logic                      err_q;
    logic                      irq_q;
    apb_pkg::addr_t            src_q;
    apb_pkg::addr_t            dst_q;
    dma_pkg::qty_t             qty_q;

    // access phase, always completed in its first cycle
    assign ofs    = cfg_paddr_i[dma_pkg::OFS_W-1:0];
    assign access = cfg_psel_i & cfg_penable_i;
    assign wr     = access & cfg_pwrite_i;

    assign mapped = (ofs == dma_pkg::REG_SRC) | (ofs == dma_pkg::REG_DST) |
                    (ofs == dma_pkg::REG_QTY) | (ofs == dma_pkg::REG_CTRL) |
                    (ofs == dma_pkg::REG_STATUS);

    assign cfg_pready_o  = access;
    assign cfg_pslverr_o = access & ~mapped;

    // start only accepted while idle
    assign start_acc = wr & (ofs == dma_pkg::REG_CTRL) &
                       cfg_pwdata_i[dma_pkg::CTRL_START] & ~busy_q;
    // write-one-to-clear on done, takes err with it
    assign clr_done  = wr & (ofs == dma_pkg::REG_STATUS) & cfg_pwdata_i[dma_pkg::STAT_DONE];

    // read mux, unmapped reads zero
    always_comb begin
        cfg_prdata_o = '0;
        case (ofs)
            dma_pkg::REG_SRC: cfg_prdata_o = src_q;
            dma_pkg::REG_DST: cfg_prdata_o = dst_q;
            dma_pkg::REG_QTY: cfg_prdata_o = apb_pkg::data_t'(qty_q);
            dma_pkg::REG_STATUS: begin
                cfg_prdata_o[dma_pkg::STAT_BUSY] = busy_q;
                cfg_prdata_o[dma_pkg::STAT_DONE] = done_q;
                cfg_prdata_o[dma_pkg::STAT_ERR]  = err_q;
            end
            default: cfg_prdata_o = '0;
        endcase
    end

    // transfer parameters, frozen while busy
    always_ff @(posedge clk) begin
        if (wr && !busy_q) begin
            if (ofs == dma_pkg::REG_SRC) begin
                src_q <= cfg_pwdata_i;
            end
            if (ofs == dma_pkg::REG_DST) begin
                dst_q <= cfg_pwdata_i;
            end
            if (ofs == dma_pkg::REG_QTY) begin
                qty_q <= cfg_pwdata_i[dma_pkg::QTY_W-1:0];
            end
        end
    end

    // control and status
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q <= 1'b0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            err_q   <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            start_q <= start_acc;
            if (fin_i) begin
                // completion beats a clear in the same cycle
                busy_q <= 1'b0;
                done_q <= 1'b1;
                err_q  <= err_i;
                irq_q  <= 1'b1;
            end else if (start_acc) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
                err_q  <= 1'b0;
                irq_q  <= 1'b0;
            end else if (clr_done) begin
                done_q <= 1'b0;
                err_q  <= 1'b0;
                irq_q  <= 1'b0;
            end
        end
    end

    assign start_o = start_q;
    assign src_o   = src_q;
    assign dst_o   = dst_q;
    assign qty_o   = qty_q;

    // fin pulse merged with the latch, so irq rises with fin
    assign irq_o = fin_i | irq_q;

endmodule

//--- dma/dma_engine.sv
module dma_engine (
    input  logic           clk,
    input  logic           rst,
    input  logic           start_i,
    input  apb_pkg::addr_t src_i,
    input  apb_pkg::addr_t dst_i,
    input  dma_pkg::qty_t  qty_i,
    output logic           mem_psel_o,
    output logic           mem_penable_o,
    output logic           mem_pwrite_o,
    output apb_pkg::addr_t mem_paddr_o,
    output apb_pkg::data_t mem_pwdata_o,
    input  apb_pkg::data_t mem_prdata_i,
    input  logic           mem_pready_i,
    input  logic           mem_pslverr_i,
    output logic           fin_o,
    output logic           err_o
);

    typedef enum logic [2:0] {
        IDLE,
        RD_SETUP,
        RD_ACCESS,
        WR_SETUP,
        WR_ACCESS,
        DONE
    } state_t;

    localparam apb_pkg::addr_t STEP = apb_pkg::addr_t'(apb_pkg::WORD_BYTES);

    state_t         state_q;
    state_t         state_d;
    apb_pkg::addr_t src_q;
    apb_pkg::addr_t dst_q;
    dma_pkg::qty_t  cnt_q;
    apb_pkg::data_t hold_q;
    logic           err_q;
    logic           rd_done;
    logic           wr_done;
    logic           last_word;

    // completed accesses
    assign rd_done   = (state_q == RD_ACCESS) & mem_pready_i;
    assign wr_done   = (state_q == WR_ACCESS) & mem_pready_i;
    assign last_word = (cnt_q == dma_pkg::qty_t'(1));

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    // empty transfer skips the bus entirely
                    state_d = (qty_i == '0) ? DONE : RD_SETUP;
                end
            end
            RD_SETUP: state_d = RD_ACCESS;
            RD_ACCESS: begin
                if (rd_done) begin
                    state_d = mem_pslverr_i ? DONE : WR_SETUP;
                end
            end
            WR_SETUP: state_d = WR_ACCESS;
            WR_ACCESS: begin
                if (wr_done) begin
                    state_d = (mem_pslverr_i || last_word) ? DONE : RD_SETUP;
                end
            end
            DONE: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && start_i) begin
                err_q <= 1'b0;
            end else if ((rd_done || wr_done) && mem_pslverr_i) begin
                err_q <= 1'b1;
            end
        end
    end

    // running addresses, word count, read data holding
    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            // low two bits ignored, word aligned only
            src_q <= {src_i[apb_pkg::ADDR_W-1:2], 2'b00};
            dst_q <= {dst_i[apb_pkg::ADDR_W-1:2], 2'b00};
            cnt_q <= qty_i;
        end else if (wr_done && !mem_pslverr_i) begin
            src_q <= src_q + STEP;
            dst_q <= dst_q + STEP;
            cnt_q <= cnt_q - dma_pkg::qty_t'(1);
        end
        if (rd_done) begin
            hold_q <= mem_prdata_i;
        end
    end

    // bus outputs decoded from state, stable from setup to pready
    assign mem_psel_o    = (state_q == RD_SETUP) | (state_q == RD_ACCESS) |
                           (state_q == WR_SETUP) | (state_q == WR_ACCESS);
    assign mem_penable_o = (state_q == RD_ACCESS) | (state_q == WR_ACCESS);
    assign mem_pwrite_o  = (state_q == WR_SETUP) | (state_q == WR_ACCESS);
    assign mem_paddr_o   = mem_pwrite_o ? dst_q : src_q;
    assign mem_pwdata_o  = hold_q;

    // one-cycle completion report
    assign fin_o = (state_q == DONE);
    assign err_o = err_q;

endmodule

//--- src/dma.sv
module dma (
    input  logic           clk,
    input  logic           rst,
    // configuration port, APB completer
    input  logic           cfg_psel_i,
    input  logic           cfg_penable_i,
    input  logic           cfg_pwrite_i,
    input  apb_pkg::addr_t cfg_paddr_i,
    input  apb_pkg::data_t cfg_pwdata_i,
    output apb_pkg::data_t cfg_prdata_o,
    output logic           cfg_pready_o,
    output logic           cfg_pslverr_o,
    // data port, APB requester
    output logic           mem_psel_o,
    output logic           mem_penable_o,
    output logic           mem_pwrite_o,
    output apb_pkg::addr_t mem_paddr_o,
    output apb_pkg::data_t mem_pwdata_o,
    input  apb_pkg::data_t mem_prdata_i,
    input  logic           mem_pready_i,
    input  logic           mem_pslverr_i,
    // transfer complete or aborted
    output logic           irq_o
);

    // regs -> engine
    logic           start;
    apb_pkg::addr_t src;
    apb_pkg::addr_t dst;
    dma_pkg::qty_t  qty;

    // engine -> regs
    logic           fin;
    logic           err;

    dma_regs dma_regs_inst (
        .clk           (clk          ),
        .rst           (rst          ),
        .cfg_psel_i    (cfg_psel_i   ),
        .cfg_penable_i (cfg_penable_i),
        .cfg_pwrite_i  (cfg_pwrite_i ),
        .cfg_paddr_i   (cfg_paddr_i  ),
        .cfg_pwdata_i  (cfg_pwdata_i ),
        .cfg_prdata_o  (cfg_prdata_o ),
        .cfg_pready_o  (cfg_pready_o ),
        .cfg_pslverr_o (cfg_pslverr_o),
        .fin_i         (fin          ),
        .err_i         (err          ),
        .start_o       (start        ),
        .src_o         (src          ),
        .dst_o         (dst          ),
        .qty_o         (qty          ),
        .irq_o         (irq_o        )
    );

    dma_engine dma_engine_inst (
        .clk           (clk          ),
        .rst           (rst          ),
        .start_i       (start        ),
        .src_i         (src          ),
        .dst_i         (dst          ),
        .qty_i         (qty          ),
        .mem_psel_o    (mem_psel_o   ),
        .mem_penable_o (mem_penable_o),
        .mem_pwrite_o  (mem_pwrite_o ),
        .mem_paddr_o   (mem_paddr_o  ),
        .mem_pwdata_o  (mem_pwdata_o ),
        .mem_prdata_i  (mem_prdata_i ),
        .mem_pready_i  (mem_pready_i ),
        .mem_pslverr_i (mem_pslverr_i),
        .fin_o         (fin          ),
        .err_o         (err          )
    );

endmodule

//--- bench/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned HALF_PERIOD  = 5;
    localparam int unsigned RESET_CYCLES = 8;

    // free running 10 ns clock
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // reset held over the first cycles, released on an edge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- bench/tb_apb_mem.sv
module tb_apb_mem (
    input  logic           clk,
    input  logic           rst,
    input  logic           psel_i,
    input  logic           penable_i,
    input  logic           pwrite_i,
    input  apb_pkg::addr_t paddr_i,
    input  apb_pkg::data_t pwdata_i,
    output apb_pkg::data_t prdata_o,
    output logic           pready_o,
    output logic           pslverr_o,
    input  apb_pkg::addr_t err_addr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned WORDS = 256;

    apb_pkg::data_t mem [WORDS];
    logic [31:0]    rng_q;
    logic [1:0]     wait_q;
    logic [7:0]     idx;
    logic           access;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word addressed, upper bits alias
    assign idx       = paddr_i[9:2];
    assign access    = psel_i & penable_i;
    assign pready_o  = access & (wait_q == 2'd0);
    // one faulty word, whole address compared
    assign pslverr_o = pready_o & (paddr_i[31:2] == err_addr_i[31:2]);
    assign prdata_o  = mem[idx];

    // 0 to 3 wait states, drawn in the setup cycle
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rng_q  <= 32'd39;
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            wait_q <= rng_q[1:0];
            rng_q  <= xorshift32(rng_q);
        end else if (access && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    // the faulty word is never written
    always @(posedge clk) begin
        if (pready_o && pwrite_i && !pslverr_o) begin
            mem[idx] <= pwdata_i;
        end
    end

endmodule

//--- bench/tb_dma.sv
module tb_dma;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned    MEM_WORDS  = 256;
    localparam int unsigned    COPY_RUNS  = 4;
    localparam int unsigned    MAX_WAIT   = 3;
    // random runs up to 16 words plus the error and busy runs
    localparam int unsigned    WORDS_ALL  = COPY_RUNS * 16 + 8 + 8;
    localparam int unsigned    REG_OPS    = 8 + 10 * (COPY_RUNS + 3);
    localparam int unsigned    LIMIT      = 2 * (WORDS_ALL * 4 * (1 + MAX_WAIT) + 50 * REG_OPS);
    localparam apb_pkg::addr_t NO_ERR     = 32'hFFFF_FFFC;

    typedef apb_pkg::data_t image_t [MEM_WORDS];

    logic           clk;
    logic           rst;
    logic           cfg_psel;
    logic           cfg_penable;
    logic           cfg_pwrite;
    apb_pkg::addr_t cfg_paddr;
    apb_pkg::data_t cfg_pwdata;
    apb_pkg::data_t cfg_prdata;
    logic           cfg_pready;
    logic           cfg_pslverr;
    logic           mem_psel;
    logic           mem_penable;
    logic           mem_pwrite;
    apb_pkg::addr_t mem_paddr;
    apb_pkg::data_t mem_pwdata;
    apb_pkg::data_t mem_prdata;
    logic           mem_pready;
    logic           mem_pslverr;
    logic           irq_o;
    apb_pkg::addr_t mem_err_addr;
    image_t         snap;
    image_t         exp_img;
    logic           check_armed;
    logic           psel_seen;
    logic [31:0]    seed;
    int             cycle_cnt = 0;

    tb_clk_gen clk_gen_inst (.clk_o(clk), .rst_o(rst));

    dma dma_inst (
        .clk(clk), .rst(rst),
        .cfg_psel_i(cfg_psel), .cfg_penable_i(cfg_penable), .cfg_pwrite_i(cfg_pwrite),
        .cfg_paddr_i(cfg_paddr), .cfg_pwdata_i(cfg_pwdata), .cfg_prdata_o(cfg_prdata),
        .cfg_pready_o(cfg_pready), .cfg_pslverr_o(cfg_pslverr),
        .mem_psel_o(mem_psel), .mem_penable_o(mem_penable), .mem_pwrite_o(mem_pwrite),
        .mem_paddr_o(mem_paddr), .mem_pwdata_o(mem_pwdata), .mem_prdata_i(mem_prdata),
        .mem_pready_i(mem_pready), .mem_pslverr_i(mem_pslverr), .irq_o(irq_o)
    );

    tb_apb_mem mem_inst (
        .clk(clk), .rst(rst),
        .psel_i(mem_psel), .penable_i(mem_penable), .pwrite_i(mem_pwrite),
        .paddr_i(mem_paddr), .pwdata_i(mem_pwdata), .prdata_o(mem_prdata),
        .pready_o(mem_pready), .pslverr_o(mem_pslverr), .err_addr_i(mem_err_addr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected image after a copy and the expected ERR bit
    function automatic logic ref_copy(input image_t pre, input apb_pkg::addr_t src,
                                      input apb_pkg::addr_t dst, input int n,
                                      input apb_pkg::addr_t err_addr, output image_t img);
        apb_pkg::addr_t s;
        apb_pkg::addr_t d;
        img = pre;
        for (int i = 0; i < n; i++) begin
            s = src + apb_pkg::addr_t'(4 * i);
            d = dst + apb_pkg::addr_t'(4 * i);
            // copy ends at the faulty word on either side
            if (s[31:2] == err_addr[31:2] || d[31:2] == err_addr[31:2]) begin
                return 1'b1;
            end
            img[d[9:2]] = img[s[9:2]];
        end
        return 1'b0;
    endfunction

    task automatic fail_now(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // one APB access with setup then access until pready
    task automatic run_access(input logic wr, input logic [7:0] ofs, input apb_pkg::data_t wd,
                              output apb_pkg::data_t rd, output logic se);
        int cycles;
        @(posedge clk);
        cfg_psel    <= 1'b1;
        cfg_penable <= 1'b0;
        cfg_pwrite  <= wr;
        cfg_paddr   <= apb_pkg::addr_t'(ofs);
        cfg_pwdata  <= wd;
        @(posedge clk);
        cfg_penable <= 1'b1;
        @(posedge clk);
        cycles = 1;
        while (!cfg_pready) begin
            @(posedge clk);
            cycles++;
        end
        rd = cfg_prdata;
        se = cfg_pslverr;
        cfg_psel    <= 1'b0;
        cfg_penable <= 1'b0;
        assert (cycles == 1)
            else fail_now($sformatf("access at %h took %0d cycles, not 2", ofs, cycles + 1));
    endtask

    task automatic write_reg(input logic [7:0] ofs, input apb_pkg::data_t wd);
        apb_pkg::data_t rd;
        logic           se;
        run_access(1'b1, ofs, wd, rd, se);
        assert (!se) else fail_now($sformatf("pslverr on write to %h", ofs));
    endtask

    task automatic read_reg(input logic [7:0] ofs, output apb_pkg::data_t rd, output logic se);
        run_access(1'b0, ofs, '0, rd, se);
    endtask

    // program and start a copy then check status and clear it
    task automatic run_copy(input apb_pkg::addr_t src, input apb_pkg::addr_t dst, input int n,
                            input apb_pkg::addr_t err_addr, input logic meddle);
        apb_pkg::data_t rd;
        apb_pkg::data_t exp_stat;
        logic           se;
        logic           exp_err;
        mem_err_addr <= err_addr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            snap[i] = mem_inst.mem[i];
        end
        exp_err = ref_copy(snap, src, dst, n, err_addr, exp_img);
        write_reg(dma_pkg::REG_SRC, src);
        write_reg(dma_pkg::REG_DST, dst);
        write_reg(dma_pkg::REG_QTY, apb_pkg::data_t'(n));
        check_armed = 1'b1;
        write_reg(dma_pkg::REG_CTRL, 32'h1);
        if (meddle) begin
            // both must be dropped while the engine runs
            write_reg(dma_pkg::REG_SRC, src ^ 32'h40);
            write_reg(dma_pkg::REG_CTRL, 32'h1);
            read_reg(dma_pkg::REG_STATUS, rd, se);
            assert (rd[dma_pkg::STAT_BUSY]) else fail_now("BUSY low during transfer");
        end
        @(posedge clk);
        while (!irq_o) @(posedge clk);
        while (check_armed) @(posedge clk);
        exp_stat = '0;
        exp_stat[dma_pkg::STAT_DONE] = 1'b1;
        exp_stat[dma_pkg::STAT_ERR]  = exp_err;
        read_reg(dma_pkg::REG_STATUS, rd, se);
        assert (rd == exp_stat) else fail_now($sformatf("status %h, expected %h", rd, exp_stat));
        assert (irq_o) else fail_now("irq dropped before DONE clear");
        write_reg(dma_pkg::REG_STATUS, 32'h1 << dma_pkg::STAT_DONE);
        read_reg(dma_pkg::REG_STATUS, rd, se);
        assert (rd == '0) else fail_now($sformatf("status %h after clear, expected 0", rd));
        assert (!irq_o) else fail_now("irq still high after DONE clear");
        if (meddle) begin
            // SRC keeps the value written before the start
            read_reg(dma_pkg::REG_SRC, rd, se);
            assert (rd == src)
                else fail_now($sformatf("SRC %h after busy write, expected %h", rd, src));
        end
    endtask

    // whole memory compared once irq is seen on an edge
    always @(posedge clk) begin
        if (check_armed && irq_o) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                assert (mem_inst.mem[i] === exp_img[i])
                    else fail_now($sformatf("word %0d is %h, expected %h",
                                            i, mem_inst.mem[i], exp_img[i]));
            end
            check_armed <= 1'b0;
        end
    end

    // any bus activity during the zero count run
    always @(posedge clk) begin
        if (mem_psel) begin
            psel_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > LIMIT) begin
            $display("timeout: transfer never completed");
            $display("Regression failed");
            $fatal(1);
        end
    end

    initial begin
        apb_pkg::data_t rd;
        apb_pkg::data_t w;
        apb_pkg::data_t exp;
        logic           se;
        cfg_psel     <= 1'b0;
        cfg_penable  <= 1'b0;
        cfg_pwrite   <= 1'b0;
        cfg_paddr    <= '0;
        cfg_pwdata   <= '0;
        mem_err_addr <= NO_ERR;
        check_armed  = 1'b0;
        psel_seen    = 1'b0;
        seed         = 32'd39;
        for (int i = 0; i < MEM_WORDS; i++) begin
            seed = xorshift32(seed);
            mem_inst.mem[i] = seed;
        end
        wait (!rst);

        // state after reset
        read_reg(dma_pkg::REG_STATUS, rd, se);
        assert (rd == '0 && !irq_o) else fail_now("status or irq not low after reset");

        // SRC, DST, QTY readback
        for (int k = 0; k < 3; k++) begin
            seed = xorshift32(seed);
            w = seed;
            write_reg(8'(4 * k), w);
            read_reg(8'(4 * k), rd, se);
            exp = (k == 2) ? apb_pkg::data_t'(w[dma_pkg::QTY_W-1:0]) : w;
            assert (rd == exp) else fail_now($sformatf("reg %0d reads %h, wrote %h", k, rd, w));
        end
        read_reg(8'h14, rd, se);
        assert (se && rd == '0) else fail_now("unmapped offset not rejected");

        // random copies from a low source to a high destination
        repeat (COPY_RUNS) begin
            seed = xorshift32(seed);
            run_copy({24'd0, seed[5:0], 2'b00}, 32'h200 + {seed[13:8], 2'b00},
                     1 + int'(seed[19:16]), NO_ERR, 1'b0);
        end

        psel_seen = 1'b0;
        run_copy(32'h10, 32'h310, 0, NO_ERR, 1'b0);
        assert (!psel_seen) else fail_now("bus access on a zero count transfer");

        // faulty fourth source word
        run_copy(32'h40, 32'h300, 8, 32'h4C, 1'b0);

        run_copy(32'h80, 32'h280, 8, NO_ERR, 1'b1);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- dma.f
common/apb_pkg.sv
common/dma_pkg.sv
dma/dma_regs.sv
dma/dma_engine.sv
src/dma.sv
bench/tb_clk_gen.sv
bench/tb_apb_mem.sv
bench/tb_dma.sv

//--- Bender.yml
package:
  name: dma

sources:
  - common/apb_pkg.sv
  - common/dma_pkg.sv
  - dma/dma_regs.sv
  - dma/dma_engine.sv
  - src/dma.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_apb_mem.sv
      - bench/tb_dma.sv
